//--- dv/dagStim.mem
// test op iSel mSel postMod dataIn newI bitRev sreq sIdx sMod mask
// expected: opReady sack iOut lOut mOut dma dmd  (mask bit0 opReady .. bit6 dmd)
1 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 1 0 0 0 0101 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 1 1 0 0 0202 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 1 2 0 0 0303 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 1 3 0 0 2404 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 2 0 0 0 1010 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 2 1 0 0 1020 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 2 2 0 0 1030 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 2 3 0 0 3040 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 3 0 0 0 0001 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 3 0 1 0 0002 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 3 0 2 0 3ffe 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 3 0 3 0 2004 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 4 0 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
2 4 1 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0101
2 4 2 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0202
2 4 3 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0303
2 5 0 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 2404
2 5 1 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 1010
2 5 2 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 1020
2 5 3 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 1030
2 6 0 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 3040
2 6 0 1 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0001
2 6 0 2 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0002
2 6 0 3 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 fffe
2 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 e004
2 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
3 7 1 2 0 0000 0000 0 0 00 00 7f 1 0 0000 0000 0000 0000 0000
3 7 3 0 0 0000 0000 1 0 00 00 7f 1 0 0202 1020 3ffe 0202 0000
3 7 0 3 0 0000 0000 1 0 00 00 7f 1 0 2404 3040 0001 0809 0000
3 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 0101 1010 2004 2020 0000
4 7 2 1 1 0000 0777 0 0 00 00 7f 1 0 0101 1010 2004 2020 0000
4 4 2 0 0 0000 0000 0 0 00 00 7f 1 0 0303 1030 0002 0303 0000
4 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 0303 1030 0002 0303 0777
5 7 0 0 0 0000 0555 0 4 10 30 7f 0 0 0303 1030 0002 0303 0000
5 7 0 0 0 0000 0555 0 4 10 30 7f 0 0 0303 1030 0002 0303 0000
5 7 0 0 0 0000 0555 0 4 10 30 7f 0 4 0202 1020 2004 0202 0000
5 7 0 0 0 0000 0555 0 0 10 30 7f 1 0 0202 1020 2004 0202 0000
5 4 1 0 0 0000 0000 0 0 00 00 7f 1 0 0101 1010 0001 0101 0000
5 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 0101 1010 0001 0101 0555
6 0 0 0 0 0000 0111 0 a c0 84 7f 0 0 0101 1010 0001 0101 0000
6 0 0 0 0 0000 0111 0 a c0 84 7f 0 0 0101 1010 0001 0101 0000
6 0 0 0 0 0000 0111 0 a c0 84 7f 0 2 0101 1010 0002 0101 0000
6 0 0 0 0 0000 0333 0 8 c0 84 7f 0 0 0101 1010 0002 0101 0000
6 0 0 0 0 0000 0333 0 8 c0 84 7f 0 0 0101 1010 0002 0101 0000
6 0 0 0 0 0000 0333 0 8 c0 84 7f 0 8 2404 3040 3ffe 2404 0000
6 4 0 0 0 0000 0000 0 0 00 00 7f 1 0 2404 3040 3ffe 2404 0000
6 4 3 0 0 0000 0000 0 0 00 00 7f 1 0 2404 3040 3ffe 2404 0111
6 0 0 0 0 0000 0000 0 0 00 00 7f 1 0 2404 3040 3ffe 2404 0333

//--- list.f
verilog/dagCfgPkg.sv
verilog/dagOpPkg.sv
verilog/dagRegBank.sv
verilog/dagControl.sv
verilog/dagAddrOut.sv
verilog/dagTop.sv
dv/dagTb.sv

//--- Bender.yml
package:
  name: dag

sources:
  - verilog/dagCfgPkg.sv
  - verilog/dagOpPkg.sv
  - verilog/dagRegBank.sv
  - verilog/dagControl.sv
  - verilog/dagAddrOut.sv
  - verilog/dagTop.sv
  - target: simulation
    files:
      - dv/dagTb.sv

//--- dv/dagTb.sv
`timescale 1ns/1ns

module dagTb import dagCfgPkg::*, dagOpPkg::*;
  ();

  localparam int AddrWidth = 14;
  localparam int BusWidth  = 16;
  localparam int NumFields = 19;                    // Columns per stimulus line.
  localparam int MaxRows   = 128;
  localparam int ClkPeriod = 40;

  logic                 DSPCLK;
  logic                 RST;
  dagOpE                op;
  regIdxT               iSel;
  regIdxT               mSel;
  logic                 postModify;
  logic [AddrWidth-1:0] dataIn;
  logic [AddrWidth-1:0] newI;
  logic                 bitRev;
  logic                 opReady;
  logic [NumChan-1:0]   sreq;
  regIdxT [NumChan-1:0] sIdx;
  regIdxT [NumChan-1:0] sMod;
  logic [NumChan-1:0]   sack;
  logic [AddrWidth-1:0] iOut;
  logic [AddrWidth-1:0] lOut;
  logic [AddrWidth-1:0] mOut;
  logic [AddrWidth-1:0] dma;
  logic [BusWidth-1:0]  dmd;

  logic [31:0] stim [NumFields*MaxRows];
  int          numRows;
  int          errors;
  int          checks;
  int          testErrors;
  int          testRows;
  int          testsRun;
  int          testsFailed;
  logic        rowsKnown;

  dagTop #(.AddrWidth(AddrWidth), .BusWidth(BusWidth)) i_dagTop (
    .DSPCLK(DSPCLK), .RST(RST), .op(op), .iSel(iSel), .mSel(mSel),
    .postModify(postModify), .dataIn(dataIn), .newI(newI), .bitRev(bitRev),
    .opReady(opReady), .sreq(sreq), .sIdx(sIdx), .sMod(sMod), .sack(sack),
    .iOut(iOut), .lOut(lOut), .mOut(mOut), .dma(dma), .dmd(dmd)
  );

  initial
  begin
    DSPCLK = 1'b0;
    forever #(ClkPeriod/2) DSPCLK = ~DSPCLK;
  end

  function automatic logic [31:0] field(int row, int col);
    return stim[row*NumFields+col];
  endfunction

  task automatic compareField(int row, int bitPos, string name, logic [31:0] got);
    logic [31:0] exp;
    logic [31:0] mask;
    exp  = field(row, 12 + bitPos);
    mask = field(row, 11);
    if (mask[bitPos])
    begin
      checks++;
      assert (got === exp)
      else
      begin
        $display("FAIL %0t row %0d %s is %h, expected %h", $time, row, name, got, exp);
        errors++;
        testErrors++;
      end
    end
  endtask

  task automatic closeTest(int id);
    testsRun++;
    if (testErrors != 0)
    begin
      testsFailed++;
    end
    $display("Test %0d: %0d cycles, %0d errors", id, testRows, testErrors);
    testErrors = 0;
    testRows   = 0;
  endtask

  task automatic applyRow(int row);
    op         <= dagOpE'(3'(field(row, 1)));
    iSel       <= regIdxT'(field(row, 2));
    mSel       <= regIdxT'(field(row, 3));
    postModify <= 1'(field(row, 4));
    dataIn     <= AddrWidth'(field(row, 5));
    newI       <= AddrWidth'(field(row, 6));
    bitRev     <= 1'(field(row, 7));
    sreq       <= NumChan'(field(row, 8));
    sIdx       <= (2*NumChan)'(field(row, 9));
    sMod       <= (2*NumChan)'(field(row, 10));
  endtask

  // Ends the run if the DUT stops making progress.
  initial
  begin
    wait (rowsKnown);
    #((numRows + 20) * ClkPeriod);
    $display("The run timed out before all stimulus lines were applied.");
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    RST        = 1'b1;
    op         = opNone;
    iSel       = '0;
    mSel       = '0;
    postModify = 1'b0;
    dataIn     = '0;
    newI       = '0;
    bitRev     = 1'b0;
    sreq       = '0;
    sIdx       = '0;
    sMod       = '0;
    errors     = 0;
    checks     = 0;
    testErrors = 0;
    testRows   = 0;
    testsRun   = 0;
    testsFailed = 0;
    rowsKnown  = 1'b0;
    for (int k = 0; k < NumFields*MaxRows; k++)
    begin
      stim[k] = '1;                                 // End marker where the file stops.
    end
    $readmemh("dv/dagStim.mem", stim);
    numRows = 0;
    while (numRows < MaxRows && field(numRows, 0) != '1)
    begin
      numRows++;
    end
    rowsKnown = 1'b1;
    repeat (4) @(posedge DSPCLK);
    RST <= 1'b0;
    for (int r = 0; r < numRows; r++)
    begin
      @(posedge DSPCLK);
      applyRow(r);
      @(negedge DSPCLK);
      compareField(r, 0, "opReady", 32'(opReady));
      compareField(r, 1, "sack", 32'(sack));
      compareField(r, 2, "iOut", 32'(iOut));
      compareField(r, 3, "lOut", 32'(lOut));
      compareField(r, 4, "mOut", 32'(mOut));
      compareField(r, 5, "dma", 32'(dma));
      compareField(r, 6, "dmd", 32'(dmd));
      testRows++;
      if (r == numRows - 1 || field(r + 1, 0) != field(r, 0))
      begin
        closeTest(field(r, 0));
      end
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checks, errors);
    if (errors == 0 && numRows > 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog/dagTop.sv
`timescale 1ns/1ns

module dagTop import dagCfgPkg::*, dagOpPkg::*; #(
  parameter int AddrWidth = 14,
  parameter int BusWidth  = 16
) (
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  dagOpE                op,
  input  regIdxT               iSel,
  input  regIdxT               mSel,
  input  logic                 postModify,
  input  logic [AddrWidth-1:0] dataIn,
  input  logic [AddrWidth-1:0] newI,
  input  logic                 bitRev,
  output logic                 opReady,
  input  logic [NumChan-1:0]   sreq,
  input  regIdxT [NumChan-1:0] sIdx,
  input  regIdxT [NumChan-1:0] sMod,
  output logic [NumChan-1:0]   sack,
  output logic [AddrWidth-1:0] iOut,
  output logic [AddrWidth-1:0] lOut,
  output logic [AddrWidth-1:0] mOut,
  output logic [AddrWidth-1:0] dma,
  output logic [BusWidth-1:0]  dmd
);

  logic                 iWrEn;
  logic                 lWrEn;
  logic                 mWrEn;
  regIdxT               wrIdx;
  logic [AddrWidth-1:0] iWrData;
  regIdxT               iRdIdx;
  regIdxT               mRdIdx;
  regIdxT               backIdx;
  logic                 addrLoad;
  rdKindE               rdKind;
  logic [AddrWidth-1:0] iVal;
  logic [AddrWidth-1:0] lVal;
  logic [AddrWidth-1:0] mVal;
  logic [AddrWidth-1:0] iBack;
  logic [AddrWidth-1:0] lBack;
  logic [AddrWidth-1:0] mBack;

  dagRegBank #(.AddrWidth(AddrWidth)) iBank (
    .DSPCLK(DSPCLK), .RST(RST), .wrEn(iWrEn), .wrIdx(wrIdx), .wrData(iWrData),
    .rdIdx(iRdIdx), .backIdx(backIdx), .rdData(iVal), .backData(iBack)
  );

  // L is addressed with the I index.
  dagRegBank #(.AddrWidth(AddrWidth)) lBank (
    .DSPCLK(DSPCLK), .RST(RST), .wrEn(lWrEn), .wrIdx(wrIdx), .wrData(dataIn),
    .rdIdx(iRdIdx), .backIdx(backIdx), .rdData(lVal), .backData(lBack)
  );

  dagRegBank #(.AddrWidth(AddrWidth)) mBank (
    .DSPCLK(DSPCLK), .RST(RST), .wrEn(mWrEn), .wrIdx(wrIdx), .wrData(dataIn),
    .rdIdx(mRdIdx), .backIdx(backIdx), .rdData(mVal), .backData(mBack)
  );

  dagControl #(.AddrWidth(AddrWidth)) u_control (
    .DSPCLK(DSPCLK), .RST(RST), .op(op), .iSel(iSel), .mSel(mSel),
    .postModify(postModify), .dataIn(dataIn), .newI(newI),
    .sreq(sreq), .sIdx(sIdx), .sMod(sMod), .opReady(opReady), .sack(sack),
    .iWrEn(iWrEn), .lWrEn(lWrEn), .mWrEn(mWrEn), .wrIdx(wrIdx), .iWrData(iWrData),
    .iRdIdx(iRdIdx), .mRdIdx(mRdIdx), .backIdx(backIdx),
    .addrLoad(addrLoad), .rdKind(rdKind)
  );

  dagAddrOut #(.AddrWidth(AddrWidth), .BusWidth(BusWidth)) u_addrOut (
    .DSPCLK(DSPCLK), .RST(RST), .addrLoad(addrLoad), .bitRev(bitRev),
    .rdKind(rdKind), .iVal(iVal), .lVal(lVal), .mVal(mVal),
    .iBack(iBack), .lBack(lBack), .mBack(mBack),
    .iOut(iOut), .lOut(lOut), .mOut(mOut), .dma(dma), .dmd(dmd)
  );

endmodule

//--- verilog/dagAddrOut.sv
`timescale 1ns/1ns

module dagAddrOut import dagOpPkg::*; #(
  parameter int AddrWidth = 14,
  parameter int BusWidth  = 16
) (
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  logic                 addrLoad,
  input  logic                 bitRev,
  input  rdKindE               rdKind,
  input  logic [AddrWidth-1:0] iVal,
  input  logic [AddrWidth-1:0] lVal,
  input  logic [AddrWidth-1:0] mVal,
  input  logic [AddrWidth-1:0] iBack,
  input  logic [AddrWidth-1:0] lBack,
  input  logic [AddrWidth-1:0] mBack,
  output logic [AddrWidth-1:0] iOut,
  output logic [AddrWidth-1:0] lOut,
  output logic [AddrWidth-1:0] mOut,
  output logic [AddrWidth-1:0] dma,
  output logic [BusWidth-1:0]  dmd
);

  logic [AddrWidth-1:0] iRev;
  logic [AddrWidth-1:0] addrNext;
  logic [BusWidth-1:0]  dmdNext;

  if (BusWidth < AddrWidth)
  begin : gBusCheck
    $error("BusWidth must be at least AddrWidth");
  end

  // Mirror the index for FFT style addressing.
  always_comb
  begin
    for (int b = 0; b < AddrWidth; b++)
    begin
      iRev[b] = iVal[AddrWidth-1-b];
    end
  end

  assign addrNext = bitRev ? iRev : iVal;

  always_comb
  begin
    case (rdKind)
      rkI:     dmdNext = BusWidth'(iBack);
      rkL:     dmdNext = BusWidth'(lBack);
      rkM:     dmdNext = BusWidth'(signed'(mBack)); // Modify values are signed.
      default: dmdNext = '0;
    endcase
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      iOut <= '0;
      lOut <= '0;
      mOut <= '0;
      dma  <= '0;
    end
    else if (addrLoad)
    begin
      iOut <= iVal;
      lOut <= lVal;
      mOut <= mVal;
      dma  <= addrNext;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      dmd <= '0;
    end
    else
    begin
      dmd <= dmdNext;                               // One cycle on the bus only.
    end
  end

  dmdIdle: assert property (@(posedge DSPCLK) disable iff (RST)
    (rdKind == rkNone) |=> (dmd == '0))
    else $error("%0t dmd driven without a readback", $time);

endmodule

//--- verilog/dagControl.sv
`timescale 1ns/1ns

module dagControl import dagCfgPkg::*, dagOpPkg::*; #(
  parameter int AddrWidth = 14
) (
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  dagOpE                op,
  input  regIdxT               iSel,
  input  regIdxT               mSel,
  input  logic                 postModify,
  input  logic [AddrWidth-1:0] dataIn,
  input  logic [AddrWidth-1:0] newI,
  input  logic [NumChan-1:0]   sreq,
  input  regIdxT [NumChan-1:0] sIdx,
  input  regIdxT [NumChan-1:0] sMod,
  output logic                 opReady,
  output logic [NumChan-1:0]   sack,
  output logic                 iWrEn,
  output logic                 lWrEn,
  output logic                 mWrEn,
  output regIdxT               wrIdx,
  output logic [AddrWidth-1:0] iWrData,
  output regIdxT               iRdIdx,
  output regIdxT               mRdIdx,
  output regIdxT               backIdx,
  output logic                 addrLoad,
  output rdKindE               rdKind
);

  stealStE stState;
  chanE    grant;
  chanE    winner;
  logic    anyReq;
  logic    accept;
  logic    stealAddr;
  logic    stealUpd;

  assign anyReq    = |sreq;
  assign stealAddr = (stState == stAddr);
  assign stealUpd  = (stState == stUpdate);

  // Lowest channel number wins.
  always_comb
  begin
    winner = chTx0;
    for (int c = NumChan - 1; c >= 0; c--)
    begin
      if (sreq[c])
      begin
        winner = chanE'(c);
      end
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      stState <= stIdle;
      grant   <= chTx0;
    end
    else
    begin
      case (stState)
        stIdle:
        begin
          if (anyReq)
          begin
            stState <= stAddr;
            grant   <= winner;                      // Held until the update ends.
          end
        end
        stAddr:  stState <= stUpdate;
        default: stState <= stIdle;
      endcase
    end
  end

  // A pending steal blocks the op port in the same cycle.
  assign opReady = (stState == stIdle) && !anyReq;
  assign accept  = opReady && (op != opNone);

  always_comb
  begin
    iWrEn    = 1'b0;
    lWrEn    = 1'b0;
    mWrEn    = 1'b0;
    addrLoad = 1'b0;
    rdKind   = rkNone;
    if (stealUpd)
    begin
      iWrEn = 1'b1;                                 // Channel's I takes newI.
    end
    else if (stealAddr)
    begin
      addrLoad = 1'b1;
    end
    else if (accept)
    begin
      case (op)
        opLoadI: iWrEn = 1'b1;
        opLoadL: lWrEn = 1'b1;
        opLoadM: mWrEn = 1'b1;
        opReadI: rdKind = rkI;
        opReadL: rdKind = rkL;
        opReadM: rdKind = rkM;
        opAddr:
        begin
          addrLoad = 1'b1;
          iWrEn    = postModify;                    // Post-modify of I[iSel].
        end
        default: rdKind = rkNone;
      endcase
    end
  end

  assign wrIdx   = stealUpd ? sIdx[grant] : ((op == opLoadM) ? mSel : iSel);
  assign iWrData = (stealUpd || (op == opAddr)) ? newI : dataIn;
  assign iRdIdx  = stealAddr ? sIdx[grant] : iSel;  // L follows the I index.
  assign mRdIdx  = stealAddr ? sMod[grant] : mSel;
  assign backIdx = (op == opReadM) ? mSel : iSel;

  always_comb
  begin
    for (int c = 0; c < NumChan; c++)
    begin
      sack[c] = stealUpd && (grant == chanE'(c));
    end
  end

  sackOneHot: assert property (@(posedge DSPCLK) disable iff (RST)
    $onehot0(sack))
    else $error("%0t more than one sack bit high", $time);

  // The channel must keep asking until it has been acknowledged.
  grantHeld: assert property (@(posedge DSPCLK) disable iff (RST)
    (stState != stIdle) |-> sreq[grant])
    else $error("%0t granted channel dropped sreq before sack", $time);

endmodule

//--- verilog/dagRegBank.sv
`timescale 1ns/1ns

module dagRegBank import dagCfgPkg::*; #(
  parameter int AddrWidth = 14
) (
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  logic                 wrEn,
  input  regIdxT               wrIdx,
  input  logic [AddrWidth-1:0] wrData,
  input  regIdxT               rdIdx,
  input  regIdxT               backIdx,
  output logic [AddrWidth-1:0] rdData,
  output logic [AddrWidth-1:0] backData
);

  localparam int NumRegs = 2 ** $bits(regIdxT);

  logic [AddrWidth-1:0] regs [NumRegs];

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      for (int r = 0; r < NumRegs; r++)
      begin
        regs[r] <= '0;
      end
    end
    else if (wrEn)
    begin
      regs[wrIdx] <= wrData;                        // Write lands at the edge.
    end
  end

  // Both read ports see the stored value, never the write data.
  assign rdData   = regs[rdIdx];                    // Addressing port.
  assign backData = regs[backIdx];                  // Data bus readback port.

  wrIdxKnown: assert property (@(posedge DSPCLK) disable iff (RST)
    wrEn |-> !$isunknown(wrIdx))
    else $error("%0t dagRegBank write with unknown index", $time);

endmodule

//--- verilog/dagOpPkg.sv
package dagOpPkg;

  // Operations offered on the external port.
  typedef enum logic [2:0]
  {
    opNone  = 3'd0,
    opLoadI = 3'd1,
    opLoadL = 3'd2,
    opLoadM = 3'd3,
    opReadI = 3'd4,
    opReadL = 3'd5,
    opReadM = 3'd6,
    opAddr  = 3'd7
  } dagOpE;

  // Steal sequencer states.
  typedef enum logic [1:0]
  {
    stIdle   = 2'd0,
    stAddr   = 2'd1,
    stUpdate = 2'd2
  } stealStE;

  // Which bank drives the data bus on readback.
  typedef enum logic [1:0]
  {
    rkNone = 2'd0,
    rkI    = 2'd1,
    rkL    = 2'd2,
    rkM    = 2'd3
  } rdKindE;

endpackage

//--- verilog/dagCfgPkg.sv
package dagCfgPkg;

  // Selects one of the four registers in an I, L or M bank.
  typedef logic [1:0] regIdxT;

  // Serial port channels that can steal an address cycle.
  localparam int NumChan = 4;

  // Order is arbitration priority, highest first.
  typedef enum logic [1:0]
  {
    chTx0 = 2'd0,
    chTx1 = 2'd1,
    chRx0 = 2'd2,
    chRx1 = 2'd3
  } chanE;

endpackage
